/* Makefile */
# Verilator build and run for the link shim testbench

SIM := obj_dir/Vtb_link_shim

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

$(SIM): tb.f $(wildcard include/*.svh verilog/*.sv test/*.sv)
	verilator --binary --timing --assert \
		--top-module tb_link_shim -Mdir obj_dir -f tb.f

clean:
	rm -rf obj_dir

/* include/link_consts.svh */
// ****************************************************************************
// Link shim constants
// Field widths, default register chain depth and the key the host uses
// to build read response data
// ****************************************************************************

`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Request address width
`define LINK_ADDR_W 16

// Read and write payload width
`define LINK_DATA_W 32

// Request tag width, tags roll over
`define LINK_TAG_W 4

// Default number of timing register stages between accelerator and host
`define LINK_STAGES 3

// Host read data is this key XORed with the zero-extended address
`define LINK_RSP_KEY 32'hA5C3_5A3C

`endif

/* tb.f */
+incdir+include
verilog/link_pkg.sv
verilog/link_tx_arbiter.sv
verilog/link_reg_stage.sv
verilog/link_rx_router.sv
verilog/link_shim_top.sv
test/link_host_model.sv
test/tb_link_shim.sv

/* test/link_host_model.sv */
// ****************************************************************************
// Behavioral host
// Answers transmit messages in order after random delays and raises
// almost-full at random for a few cycles at a time
// ****************************************************************************

`timescale 1ns/1ns

`include "link_consts.svh"

module link_host_model
    import link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_valid,
    input  link_op_t                tx_op,
    input  logic [`LINK_ADDR_W-1:0] tx_addr,
    input  logic [`LINK_TAG_W-1:0]  tx_tag,
    output logic                    rx_valid,
    output link_op_t                rx_op,
    output logic [`LINK_DATA_W-1:0] rx_data,
    output logic [`LINK_TAG_W-1:0]  rx_tag,
    output logic                    almost_full
);

    // Output registers start idle
    logic                    rx_valid_q = 1'b0;
    link_op_t                rx_op_q = OP_READ;
    logic [`LINK_DATA_W-1:0] rx_data_q = '0;
    logic [`LINK_TAG_W-1:0]  rx_tag_q = '0;
    logic                    af_q = 1'b0;

    // Pending responses in arrival order and the cycle each one is due
    link_op_t                q_op   [$];
    logic [`LINK_DATA_W-1:0] q_data [$];
    logic [`LINK_TAG_W-1:0]  q_tag  [$];
    int                      q_due  [$];

    int seed = 34;
    int cycle = 0;
    int last_due = 0;
    int due = 0;
    int af_left = 0;

    assign rx_valid    = rx_valid_q;
    assign rx_op       = rx_op_q;
    assign rx_data     = rx_data_q;
    assign rx_tag      = rx_tag_q;
    assign almost_full = af_q;

    always @(posedge clk)
    begin
        if (rst)
        begin
            rx_valid_q <= 1'b0;
            af_q       <= 1'b0;
            cycle = 0;
            last_due = 0;
            af_left = 0;
        end
        else
        begin
            cycle = cycle + 1;
            if (tx_valid)
            begin
                // Random delay of 0 to 7 cycles
                // Responses stay in order and leave one per cycle
                due = cycle + ($random(seed) & 7);
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                q_op.push_back(tx_op);
                q_data.push_back((tx_op == OP_READ) ?
                                 ({16'b0, tx_addr} ^ `LINK_RSP_KEY) : '0);
                q_tag.push_back(tx_tag);
                q_due.push_back(due);
            end

            if (q_due.size() > 0 && q_due[0] <= cycle)
            begin
                rx_valid_q <= 1'b1;
                rx_op_q    <= q_op.pop_front();
                rx_data_q  <= q_data.pop_front();
                rx_tag_q   <= q_tag.pop_front();
                due = q_due.pop_front();
            end
            else
                rx_valid_q <= 1'b0;

            // Occasional almost-full bursts of 1 to 8 cycles
            if (af_left > 0)
                af_left = af_left - 1;
            else if (($random(seed) & 15) == 0)
                af_left = 1 + ($random(seed) & 7);
            af_q <= (af_left > 0);
        end
    end

endmodule

/* test/tb_link_shim.sv */
// ****************************************************************************
// Link shim testbench
// Random read and write traffic through the shim with a behavioral host,
// checked by assertions on latency, content, responses and arbitration
// ****************************************************************************

`timescale 1ns/1ns

`include "link_consts.svh"

module tb_link_shim
    import link_pkg::*;
;

    localparam int WATCHDOG_CYCLES = 80 * 20 + 200;

    logic clk = 1'b0;
    logic rst;
    logic rd_req;
    logic wr_req;
    logic fiu_error;
    logic arm;
    logic [`LINK_ADDR_W-1:0] rd_addr;
    logic [`LINK_ADDR_W-1:0] wr_addr;
    logic [`LINK_DATA_W-1:0] wr_data;
    logic rd_grant;
    logic wr_grant;
    logic rd_rsp_valid;
    logic wr_ack_valid;
    logic afu_reset;
    logic afu_error;
    logic [`LINK_DATA_W-1:0] rd_rsp_data;
    logic [`LINK_DATA_W-1:0] fiu_rx_data;
    logic [`LINK_DATA_W-1:0] fiu_tx_data;
    logic [`LINK_TAG_W-1:0]  rd_rsp_tag;
    logic [`LINK_TAG_W-1:0]  wr_ack_tag;
    logic [`LINK_TAG_W-1:0]  fiu_rx_tag;
    logic [`LINK_TAG_W-1:0]  fiu_tx_tag;
    logic fiu_almost_full;
    logic fiu_rx_valid;
    logic fiu_tx_valid;
    link_op_t fiu_rx_op;
    link_op_t fiu_tx_op;
    logic [`LINK_ADDR_W-1:0] fiu_tx_addr;

    int seed = 34;
    int errors = 0;
    int af_cnt = 0;
    logic [`LINK_TAG_W-1:0] exp_tag;

    // Grants not yet seen on the host side
    link_op_t                gq_op   [$];
    logic [`LINK_ADDR_W-1:0] gq_addr [$];
    logic [`LINK_DATA_W-1:0] gq_data [$];
    logic [`LINK_TAG_W-1:0]  gq_tag  [$];

    // Messages sent to the host and not yet answered
    link_op_t                rq_op   [$];
    logic [`LINK_ADDR_W-1:0] rq_addr [$];
    logic [`LINK_TAG_W-1:0]  rq_tag  [$];

    always #50 clk = ~clk;

    link_shim_top dut0 (.*);

    link_host_model host (
        .clk         (clk),
        .rst         (rst),
        .tx_valid    (fiu_tx_valid),
        .tx_op       (fiu_tx_op),
        .tx_addr     (fiu_tx_addr),
        .tx_tag      (fiu_tx_tag),
        .rx_valid    (fiu_rx_valid),
        .rx_op       (fiu_rx_op),
        .rx_data     (fiu_rx_data),
        .rx_tag      (fiu_rx_tag),
        .almost_full (fiu_almost_full)
    );

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
    endtask

    // Each request is held until granted and then replaced by a new one
    task automatic run_requests(input int n_rd, input int n_wr);
        int rd_left;
        int wr_left;
        rd_left = n_rd;
        wr_left = n_wr;
        rd_req  <= (rd_left > 0);
        rd_addr <= 16'($random(seed));
        wr_req  <= (wr_left > 0);
        wr_addr <= 16'($random(seed));
        wr_data <= $random(seed);
        while (rd_left > 0 || wr_left > 0)
        begin
            @(posedge clk);
            if (rd_req && rd_grant)
            begin
                rd_left--;
                rd_req  <= (rd_left > 0);
                rd_addr <= 16'($random(seed));
            end
            if (wr_req && wr_grant)
            begin
                wr_left--;
                wr_req  <= (wr_left > 0);
                wr_addr <= 16'($random(seed));
                wr_data <= $random(seed);
            end
        end
    endtask

    // Reset state and reset release timing
    assert property (@(posedge clk) disable iff (!arm)
        afu_reset |-> !rd_grant && !wr_grant && !fiu_tx_valid && !rd_rsp_valid
                      && !wr_ack_valid && !afu_error)
        else note_failure("an output was active while afu_reset was high");
    assert property (@(posedge clk) disable iff (!arm)
        $fell(rst) |-> ##`LINK_STAGES $fell(afu_reset))
        else note_failure("afu_reset did not fall on time after rst");

    // Transmit latency
    assert property (@(posedge clk) disable iff (afu_reset)
        (rd_grant || wr_grant) |-> ##(`LINK_STAGES+1) fiu_tx_valid)
        else flag_mismatch("fiu_tx_valid", 1, 0);

    // Back-to-back grants with both ports held must alternate
    assert property (@(posedge clk) disable iff (afu_reset)
        (rd_grant || wr_grant) && $past(rd_grant || wr_grant) && rd_req && wr_req
        && $past(rd_req && wr_req) |-> rd_grant != $past(rd_grant))
        else flag_mismatch("rd_grant", 32'(!$past(rd_grant)), 32'(rd_grant));

    // Error level delay
    assert property (@(posedge clk) disable iff (afu_reset || !arm)
        afu_error == $past(fiu_error, `LINK_STAGES))
        else flag_mismatch("afu_error", 32'($past(fiu_error, `LINK_STAGES)),
                           32'(afu_error));

    // Scoreboard for grants, host-side messages and responses
    always @(posedge clk)
    begin
        if (afu_reset)
            exp_tag <= '0;
        else if (rd_grant || wr_grant)
        begin
            gq_op.push_back(rd_grant ? OP_READ : OP_WRITE);
            gq_addr.push_back(rd_grant ? rd_addr : wr_addr);
            gq_data.push_back(rd_grant ? '0 : wr_data);
            gq_tag.push_back(exp_tag);
            exp_tag <= exp_tag + 1'b1;
        end

        if (fiu_tx_valid && gq_op.size() == 0)
            note_failure("fiu_tx message without a matching grant");
        else if (fiu_tx_valid)
        begin
            assert (fiu_tx_op == gq_op[0])
                else flag_mismatch("fiu_tx_op", 32'(gq_op[0]), 32'(fiu_tx_op));
            assert (fiu_tx_addr == gq_addr[0])
                else flag_mismatch("fiu_tx_addr", 32'(gq_addr[0]), 32'(fiu_tx_addr));
            assert (fiu_tx_data == gq_data[0])
                else flag_mismatch("fiu_tx_data", gq_data[0], fiu_tx_data);
            assert (fiu_tx_tag == gq_tag[0])
                else flag_mismatch("fiu_tx_tag", 32'(gq_tag[0]), 32'(fiu_tx_tag));
            rq_op.push_back(gq_op.pop_front());
            rq_addr.push_back(gq_addr.pop_front());
            rq_tag.push_back(gq_tag.pop_front());
            gq_data.delete(0);
        end

        if ((rd_rsp_valid || wr_ack_valid) && rq_op.size() == 0)
            note_failure("response arrived with no request outstanding");
        else if (rd_rsp_valid || wr_ack_valid)
        begin
            assert (rq_op[0] == (rd_rsp_valid ? OP_READ : OP_WRITE))
                else note_failure("response came back on the wrong port");
            if (rd_rsp_valid)
            begin
                assert (rd_rsp_tag == rq_tag[0])
                    else flag_mismatch("rd_rsp_tag", 32'(rq_tag[0]), 32'(rd_rsp_tag));
                assert (rd_rsp_data == ({16'b0, rq_addr[0]} ^ `LINK_RSP_KEY))
                    else flag_mismatch("rd_rsp_data", {16'b0, rq_addr[0]} ^ `LINK_RSP_KEY,
                                       rd_rsp_data);
            end
            else
                assert (wr_ack_tag == rq_tag[0])
                    else flag_mismatch("wr_ack_tag", 32'(rq_tag[0]), 32'(wr_ack_tag));
            rq_op.delete(0);
            rq_addr.delete(0);
            rq_tag.delete(0);
        end

        // Messages seen while almost-full stays high
        if (!fiu_almost_full)
            af_cnt = 0;
        else if (fiu_tx_valid)
            af_cnt = af_cnt + 1;
        assert (af_cnt <= `LINK_STAGES + 2)
            else flag_mismatch("fiu_tx count under almost-full", `LINK_STAGES + 2,
                               32'(af_cnt));
    end

    // Host error level pulses
    initial
    begin
        repeat (60) @(posedge clk);
        fiu_error <= 1'b1;
        repeat (7) @(posedge clk);
        fiu_error <= 1'b0;
        repeat (45) @(posedge clk);
        fiu_error <= 1'b1;
        repeat (3) @(posedge clk);
        fiu_error <= 1'b0;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        // Both ports request through reset and must not be granted
        rd_req = 1'b1;
        wr_req = 1'b1;
        rd_addr = '0;
        wr_addr = '0;
        wr_data = '0;
        fiu_error = 1'b0;
        arm = 1'b0;
        repeat (2) @(posedge clk);
        arm <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        while (afu_reset)
            @(posedge clk);
        run_requests(10, 0);
        run_requests(0, 10);
        // Both ports held for the rest
        run_requests(30, 30);
        while (gq_op.size() != 0 || rq_op.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog/link_pkg.sv */
// ****************************************************************************
// Link shim package
// Message opcode and arbiter state types shared by the shim blocks
// ****************************************************************************

package link_pkg;

    // Message kind carried with every transmit and receive message
    // Reads and writes share the channel, so one bit is enough
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    }
    link_op_t;

    // Which request port won the last arbitration
    // Used to give the other side priority when both are pending
    typedef enum logic
    {
        LAST_READ  = 1'b0,
        LAST_WRITE = 1'b1
    }
    arb_state_t;

endpackage

/* verilog/link_reg_stage.sv */
// ****************************************************************************
// Link register stage
// One timing register on every field of the transmit and receive
// channels, plus the delayed reset and the host error level
// ****************************************************************************

`timescale 1ns/1ns

`include "link_consts.svh"

module link_reg_stage
    import link_pkg::*;
(
    input  logic                    clk,

    // Reset chain, travels toward the accelerator side
    input  logic                    rst_in,
    output logic                    rst_out,

    // Transmit direction, accelerator to host
    input  logic                    tx_valid_in,
    input  link_op_t                tx_op_in,
    input  logic [`LINK_ADDR_W-1:0] tx_addr_in,
    input  logic [`LINK_DATA_W-1:0] tx_data_in,
    input  logic [`LINK_TAG_W-1:0]  tx_tag_in,
    output logic                    tx_valid_out,
    output link_op_t                tx_op_out,
    output logic [`LINK_ADDR_W-1:0] tx_addr_out,
    output logic [`LINK_DATA_W-1:0] tx_data_out,
    output logic [`LINK_TAG_W-1:0]  tx_tag_out,

    // Receive direction, host to accelerator
    input  logic                    rx_valid_in,
    input  link_op_t                rx_op_in,
    input  logic [`LINK_DATA_W-1:0] rx_data_in,
    input  logic [`LINK_TAG_W-1:0]  rx_tag_in,
    output logic                    rx_valid_out,
    output link_op_t                rx_op_out,
    output logic [`LINK_DATA_W-1:0] rx_data_out,
    output logic [`LINK_TAG_W-1:0]  rx_tag_out,

    // Host error level
    input  logic                    error_in,
    output logic                    error_out
);

    // Delayed reset starts asserted so downstream logic is held from power-up
    logic rst_q = 1'b1;

    always_ff @(posedge clk)
    begin
        rst_q <= rst_in;
    end

    assign rst_out = rst_q;

    // Strobes and the error level are cleared by this stage's own reset copy
    always_ff @(posedge clk)
    begin
        if (rst_in)
        begin
            tx_valid_out <= 1'b0;
            rx_valid_out <= 1'b0;
            error_out    <= 1'b0;
        end
        else
        begin
            tx_valid_out <= tx_valid_in;
            rx_valid_out <= rx_valid_in;
            error_out    <= error_in;
        end
    end

    // Payload fields just follow, one message per direction in this stage
    always_ff @(posedge clk)
    begin
        tx_op_out   <= tx_op_in;
        tx_addr_out <= tx_addr_in;
        tx_data_out <= tx_data_in;
        tx_tag_out  <= tx_tag_in;
        rx_op_out   <= rx_op_in;
        rx_data_out <= rx_data_in;
        rx_tag_out  <= rx_tag_in;
    end

endmodule

/* verilog/link_rx_router.sv */
// ****************************************************************************
// Receive router
// Registered demultiplexer that steers host responses by opcode to the
// read response port or the write acknowledge port
// ****************************************************************************

`timescale 1ns/1ns

`include "link_consts.svh"

module link_rx_router
    import link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // Responses leaving the register chain
    input  logic                    rx_valid,
    input  link_op_t                rx_op,
    input  logic [`LINK_DATA_W-1:0] rx_data,
    input  logic [`LINK_TAG_W-1:0]  rx_tag,

    // Read response port
    output logic                    rd_rsp_valid,
    output logic [`LINK_DATA_W-1:0] rd_rsp_data,
    output logic [`LINK_TAG_W-1:0]  rd_rsp_tag,

    // Write acknowledge port
    output logic                    wr_ack_valid,
    output logic [`LINK_TAG_W-1:0]  wr_ack_tag
);

    logic is_rd;
    logic is_wr;

    // Decode the response kind
    assign is_rd = rx_valid && (rx_op == OP_READ);
    assign is_wr = rx_valid && (rx_op == OP_WRITE);

    // Single-cycle strobes, one per incoming response
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_rsp_valid <= 1'b0;
            wr_ack_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= is_rd;
            wr_ack_valid <= is_wr;
        end
    end

    // Payload only loads on its own kind and holds otherwise
    always_ff @(posedge clk)
    begin
        if (is_rd)
        begin
            rd_rsp_data <= rx_data;
            rd_rsp_tag  <= rx_tag;
        end

        if (is_wr)
        begin
            // Write acks have no data, only the tag comes back
            wr_ack_tag <= rx_tag;
        end
    end

endmodule

/* verilog/link_shim_top.sv */
// ****************************************************************************
// Link shim top level
// Arbiter, a chain of timing register stages and the response router
// Almost-full bypasses the chain through a single edge register
// ****************************************************************************

`timescale 1ns/1ns

`include "link_consts.svh"

module link_shim_top
    import link_pkg::*;
#(
    // Register chain depth, at least 1
    parameter int N_STAGES = `LINK_STAGES
)
(
    input  logic                    clk,
    input  logic                    rst,

    // Accelerator request and response ports
    input  logic                    rd_req,
    input  logic [`LINK_ADDR_W-1:0] rd_addr,
    output logic                    rd_grant,
    input  logic                    wr_req,
    input  logic [`LINK_ADDR_W-1:0] wr_addr,
    input  logic [`LINK_DATA_W-1:0] wr_data,
    output logic                    wr_grant,
    output logic                    rd_rsp_valid,
    output logic [`LINK_DATA_W-1:0] rd_rsp_data,
    output logic [`LINK_TAG_W-1:0]  rd_rsp_tag,
    output logic                    wr_ack_valid,
    output logic [`LINK_TAG_W-1:0]  wr_ack_tag,
    output logic                    afu_reset,
    output logic                    afu_error,

    // Host side
    input  logic                    fiu_almost_full,
    input  logic                    fiu_rx_valid,
    input  link_op_t                fiu_rx_op,
    input  logic [`LINK_DATA_W-1:0] fiu_rx_data,
    input  logic [`LINK_TAG_W-1:0]  fiu_rx_tag,
    input  logic                    fiu_error,
    output logic                    fiu_tx_valid,
    output link_op_t                fiu_tx_op,
    output logic [`LINK_ADDR_W-1:0] fiu_tx_addr,
    output logic [`LINK_DATA_W-1:0] fiu_tx_data,
    output logic [`LINK_TAG_W-1:0]  fiu_tx_tag
);

    // Chain boundaries, index 0 is the accelerator side
    // Transmit and reset flow up in index, receive and error flow down
    logic                    rst_s      [N_STAGES+1];
    logic                    tx_valid_s [N_STAGES+1];
    link_op_t                tx_op_s    [N_STAGES+1];
    logic [`LINK_ADDR_W-1:0] tx_addr_s  [N_STAGES+1];
    logic [`LINK_DATA_W-1:0] tx_data_s  [N_STAGES+1];
    logic [`LINK_TAG_W-1:0]  tx_tag_s   [N_STAGES+1];
    logic                    rx_valid_s [N_STAGES+1];
    link_op_t                rx_op_s    [N_STAGES+1];
    logic [`LINK_DATA_W-1:0] rx_data_s  [N_STAGES+1];
    logic [`LINK_TAG_W-1:0]  rx_tag_s   [N_STAGES+1];
    logic                    err_s      [N_STAGES+1];

    // Host almost-full, registered once and held high through reset
    logic                    af_q = 1'b1;

    always_ff @(posedge clk)
    begin
        if (afu_reset)
            af_q <= 1'b1;
        else
            af_q <= fiu_almost_full;
    end

    // Chain end points
    assign rst_s[0]             = rst;
    assign afu_reset            = rst_s[N_STAGES];
    assign rx_valid_s[N_STAGES] = fiu_rx_valid;
    assign rx_op_s[N_STAGES]    = fiu_rx_op;
    assign rx_data_s[N_STAGES]  = fiu_rx_data;
    assign rx_tag_s[N_STAGES]   = fiu_rx_tag;
    assign err_s[N_STAGES]      = fiu_error;
    assign afu_error            = err_s[0];
    assign fiu_tx_valid         = tx_valid_s[N_STAGES];
    assign fiu_tx_op            = tx_op_s[N_STAGES];
    assign fiu_tx_addr          = tx_addr_s[N_STAGES];
    assign fiu_tx_data          = tx_data_s[N_STAGES];
    assign fiu_tx_tag           = tx_tag_s[N_STAGES];

    link_tx_arbiter arb (
        .clk         (clk),
        .rst         (afu_reset),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_grant    (rd_grant),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_grant    (wr_grant),
        .almost_full (af_q),
        .tx_valid    (tx_valid_s[0]),
        .tx_op       (tx_op_s[0]),
        .tx_addr     (tx_addr_s[0]),
        .tx_data     (tx_data_s[0]),
        .tx_tag      (tx_tag_s[0])
    );

    // Stage k sits between boundary k and boundary k+1
    for (genvar k = 0; k < N_STAGES; k++)
    begin : g_stage
        link_reg_stage stage (
            .clk          (clk),
            .rst_in       (rst_s[k]),
            .rst_out      (rst_s[k+1]),
            .tx_valid_in  (tx_valid_s[k]),
            .tx_op_in     (tx_op_s[k]),
            .tx_addr_in   (tx_addr_s[k]),
            .tx_data_in   (tx_data_s[k]),
            .tx_tag_in    (tx_tag_s[k]),
            .tx_valid_out (tx_valid_s[k+1]),
            .tx_op_out    (tx_op_s[k+1]),
            .tx_addr_out  (tx_addr_s[k+1]),
            .tx_data_out  (tx_data_s[k+1]),
            .tx_tag_out   (tx_tag_s[k+1]),
            .rx_valid_in  (rx_valid_s[k+1]),
            .rx_op_in     (rx_op_s[k+1]),
            .rx_data_in   (rx_data_s[k+1]),
            .rx_tag_in    (rx_tag_s[k+1]),
            .rx_valid_out (rx_valid_s[k]),
            .rx_op_out    (rx_op_s[k]),
            .rx_data_out  (rx_data_s[k]),
            .rx_tag_out   (rx_tag_s[k]),
            .error_in     (err_s[k+1]),
            .error_out    (err_s[k])
        );
    end

    link_rx_router router (
        .clk          (clk),
        .rst          (afu_reset),
        .rx_valid     (rx_valid_s[0]),
        .rx_op        (rx_op_s[0]),
        .rx_data      (rx_data_s[0]),
        .rx_tag       (rx_tag_s[0]),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_data  (rd_rsp_data),
        .rd_rsp_tag   (rd_rsp_tag),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_tag   (wr_ack_tag)
    );

endmodule

/* verilog/link_tx_arbiter.sv */
// ****************************************************************************
// Transmit arbiter
// Round-robin merge of the read and write request ports into one tagged
// transmit stream, held off while the host is almost full
// ****************************************************************************

`timescale 1ns/1ns

`include "link_consts.svh"

module link_tx_arbiter
    import link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // Read request port
    input  logic                    rd_req,
    input  logic [`LINK_ADDR_W-1:0] rd_addr,
    output logic                    rd_grant,

    // Write request port
    input  logic                    wr_req,
    input  logic [`LINK_ADDR_W-1:0] wr_addr,
    input  logic [`LINK_DATA_W-1:0] wr_data,
    output logic                    wr_grant,

    // Registered host almost-full level
    input  logic                    almost_full,

    // Merged transmit stream toward the register chain
    output logic                    tx_valid,
    output link_op_t                tx_op,
    output logic [`LINK_ADDR_W-1:0] tx_addr,
    output logic [`LINK_DATA_W-1:0] tx_data,
    output logic [`LINK_TAG_W-1:0]  tx_tag
);

    arb_state_t                  last_win;
    logic [`LINK_TAG_W-1:0]      tag_cnt;
    logic                        rd_pend;
    logic                        wr_pend;

    // Nothing is granted while the host side is filling up
    assign rd_pend = rd_req && !almost_full;
    assign wr_pend = wr_req && !almost_full;

    // A lone request wins outright
    // With both pending, the side that lost last time goes first
    assign rd_grant = rd_pend && (!wr_pend || (last_win == LAST_WRITE));
    assign wr_grant = wr_pend && (!rd_pend || (last_win == LAST_READ));

    // Control state: valid strobe, round-robin pointer and tag counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_valid <= 1'b0;
            // Reads get first pick after reset
            last_win <= LAST_WRITE;
            tag_cnt  <= '0;
        end
        else
        begin
            tx_valid <= rd_grant || wr_grant;

            if (rd_grant)
            begin
                last_win <= LAST_READ;
            end
            else if (wr_grant)
            begin
                last_win <= LAST_WRITE;
            end

            // Rolling tag, one step per accepted request
            if (rd_grant || wr_grant)
            begin
                tag_cnt <= tag_cnt + 1'b1;
            end
        end
    end

    // Payload of the granted request, qualified by tx_valid
    always_ff @(posedge clk)
    begin
        if (rd_grant)
        begin
            tx_op   <= OP_READ;
            tx_addr <= rd_addr;
            // Reads carry no data
            tx_data <= '0;
            tx_tag  <= tag_cnt;
        end
        else if (wr_grant)
        begin
            tx_op   <= OP_WRITE;
            tx_addr <= wr_addr;
            tx_data <= wr_data;
            tx_tag  <= tag_cnt;
        end
    end

endmodule
